// ==== filelist.f ====
source/filter_cfg_pkg.sv
source/cfg_response_sequencer.sv
source/config_fifo.sv
source/filter_cond_config_loader.sv
source/config_drain_arbiter.sv
source/filter_config_top.sv
sim/filter_config_asserts.sv
sim/tb_filter_config.sv

// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --assert -Wno-fatal --top-module tb_filter_config -f filelist.f -o tb_filter_config
	@out=$$(./obj_dir/tb_filter_config); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== sim/tb_filter_config.sv ====
// Filter configuration loader testbench
`timescale 1ns/1ns
`default_nettype none

module tb_filter_config;

    import filter_cfg_pkg::*;

    // Words over all tests, for the watchdog
    localparam int TOTAL_WORDS     = 8 + 32 + 32 + 64 + 5 + 32;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 400;
    localparam int DRAIN_LIMIT     = 100;
    localparam int QUIET_CYCLES    = 20;

    logic                 ap_clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 cfg_start = 1'b0;
    logic                 word_valid = 1'b0;
    type_cfg_data         word_data = '0;
    tagged_config         config_out;
    logic                 setup_busy;
    logic [NUM_LANES-1:0] overflow;

    integer seed = 32'h4d10ff0f;
    int     errors = 0;
    int     errors_base = 0;
    int     received = 0;
    int     received_base = 0;
    int     model_offset = 0;
    logic   busy_check_on = 1'b0;
    int     lane_count [NUM_LANES];
    logic [CFG_SEQ_WIDTH-1:0][CFG_DATA_BITS-1:0] lane_words [NUM_LANES];
    filter_cond_param expected_q [NUM_LANES][$];

    always #5 ap_clk = ~ap_clk;

    filter_config_top u_dut (
        .ap_clk     (ap_clk),
        .reset      (reset),
        .cfg_start  (cfg_start),
        .word_valid (word_valid),
        .word_data  (word_data),
        .config_out (config_out),
        .setup_busy (setup_busy),
        .overflow   (overflow)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Field order of a window, low bits of each word
    function automatic filter_cond_param expected_record(
        input logic [CFG_SEQ_WIDTH-1:0][CFG_DATA_BITS-1:0] words
    );
        filter_cond_param rec;
        rec.operation   = type_filter_operation'(words[0][2:0]);
        rec.filter_mask = words[1][3:0];
        rec.const_mask  = words[2][3:0];
        rec.const_value = words[3];
        rec.ops_mask    = words[4][15:0];
        {rec.conditional_flag, rec.ternary_flag, rec.continue_flag, rec.filter_pass,
         rec.filter_post, rec.break_pass, rec.break_flag} = words[5][6:0];
        rec.route_if    = words[6][7:0];
        rec.route_else  = words[7][7:0];
        return rec;
    endfunction

    function automatic int pending();
        int total;
        total = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            total += expected_q[i].size();
        end
        return total;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic drive_word(input logic start, input int gap);
        type_cfg_data data;
        int           lane;
        int           pos;
        data = $random(seed);
        if (start) begin
            model_offset = 0;
        end
        lane = model_offset / CFG_SEQ_WIDTH;
        pos  = model_offset % CFG_SEQ_WIDTH;
        lane_words[lane][pos] = data;
        // A record completes only from an unbroken window
        if (pos == 0) begin
            lane_count[lane] = 1;
        end else if (lane_count[lane] == pos) begin
            lane_count[lane]++;
        end
        if (lane_count[lane] == CFG_SEQ_WIDTH) begin
            expected_q[lane].push_back(expected_record(lane_words[lane]));
            lane_count[lane] = 0;
        end
        model_offset = (model_offset + 1) % (1 << CFG_OFFSET_BITS);
        @(posedge ap_clk);
        cfg_start  <= start;
        word_valid <= 1'b1;
        word_data  <= data;
        repeat (gap) begin
            @(posedge ap_clk);
            cfg_start  <= 1'b0;
            word_valid <= 1'b0;
        end
    endtask

    task automatic send_words(input int count, input int max_gap);
        for (int i = 0; i < count; i++) begin
            drive_word(i == 0, (max_gap > 0) ? ({$random(seed)} % (max_gap + 1)) : 0);
        end
    endtask

    task automatic end_test(input string name, input int records);
        int waited;
        waited = 0;
        @(posedge ap_clk);
        cfg_start  <= 1'b0;
        word_valid <= 1'b0;
        while (pending() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge ap_clk);
            waited++;
        end
        repeat (QUIET_CYCLES) @(posedge ap_clk);
        assert (pending() == 0 && received - received_base == records) else begin
            $display("Test %s expected %0d records but received %0d", name, records,
                     received - received_base);
            errors++;
        end
        assert (overflow == '0) else begin
            $display("Mismatch overflow: expected 0x0, got 0x%h", overflow);
            errors++;
        end
        $display("Test %s finished: %0d records, %0d errors", name,
                 received - received_base, errors - errors_base);
        received_base = received;
        errors_base   = errors;
    endtask

    // ------------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------------
    always @(posedge ap_clk) begin : compare_block
        filter_cond_param want;
        if (busy_check_on) begin
            assert (!setup_busy) else begin
                $display("setup_busy went high after reset was released");
                errors++;
            end
        end
        if (!reset && config_out.valid) begin
            received++;
            if (expected_q[config_out.lane].size() == 0) begin
                $display("Record arrived for lane %0d with none expected", config_out.lane);
                errors++;
            end else begin
                want = expected_q[config_out.lane].pop_front();
                assert (config_out.param == want) else begin
                    $display("Mismatch config_out.param lane %0d: expected 0x%h, got 0x%h",
                             config_out.lane, want, config_out.param);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        repeat (8) @(posedge ap_clk);
        reset <= 1'b0;
        repeat (4) @(posedge ap_clk);
        busy_check_on <= 1'b1;
        send_words(8, 0);
        end_test("single lane", 1);
        send_words(32, 0);
        end_test("full region", 4);
        send_words(32, 3);
        end_test("gapped stream", 4);
        send_words(64, 0);
        end_test("reload", 8);
        send_words(5, 0);
        send_words(32, 0);
        end_test("restart", 4);
        $display("Tests done: %0d records checked, %0d errors", received, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/filter_config_asserts.sv ====
// Drain arbiter assertions
`timescale 1ns/1ns
`default_nettype none

module filter_config_asserts (
    input  logic                                 ap_clk,
    input  logic                                 reset,
    input  filter_cfg_pkg::lane_fifo_status      statuses [filter_cfg_pkg::NUM_LANES],
    input  logic [filter_cfg_pkg::NUM_LANES-1:0] pops,
    input  filter_cfg_pkg::tagged_config         config_out
);

    import filter_cfg_pkg::*;

    logic [NUM_LANES-1:0] lane_empty;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_empty[i] = statuses[i].empty;
        end
    end

    // At most one lane served per cycle
    pops_onehot: assert property (@(posedge ap_clk) disable iff (reset) $onehot0(pops))
        else $error("pops is not one-hot: 0x%h", pops);

    pop_not_empty: assert property (@(posedge ap_clk) disable iff (reset)
        (pops & lane_empty) == '0)
        else $error("pop issued to an empty lane: pops 0x%h empty 0x%h", pops, lane_empty);

    // Output register cleared by a reset cycle
    valid_after_reset: assert property (@(posedge ap_clk)
        $past(reset) |-> config_out.valid !== 1'b1)
        else $error("config_out.valid high after a reset cycle");

endmodule

bind config_drain_arbiter filter_config_asserts u_asserts (
    .ap_clk     (ap_clk),
    .reset      (reset),
    .statuses   (statuses),
    .pops       (pops),
    .config_out (config_out)
);

`default_nettype wire

// ==== source/filter_config_top.sv ====
// Filter configuration loader top
`timescale 1ns/1ns
`default_nettype none

module filter_config_top (
    input  logic                                 ap_clk,
    input  logic                                 reset,
    input  logic                                 cfg_start,
    input  logic                                 word_valid,
    input  filter_cfg_pkg::type_cfg_data         word_data,
    output filter_cfg_pkg::tagged_config         config_out,
    output logic                                 setup_busy,
    output logic [filter_cfg_pkg::NUM_LANES-1:0] overflow
);

    import filter_cfg_pkg::*;

    cfg_response          response;
    filter_cond_param     heads [NUM_LANES];
    lane_fifo_status      statuses [NUM_LANES];
    logic [NUM_LANES-1:0] pops;
    logic [NUM_LANES-1:0] fifo_reset_busy;

    // Offset tagging, broadcast to every lane
    cfg_response_sequencer u_sequencer (
        .ap_clk     (ap_clk),
        .reset      (reset),
        .cfg_start  (cfg_start),
        .word_valid (word_valid),
        .word_data  (word_data),
        .response   (response)
    );

    // --------------------------------------------------------------------------
    // Lane loaders
    // --------------------------------------------------------------------------
    for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
        filter_cond_config_loader #(
            .LANE_INDEX (lane)
        ) u_loader (
            .ap_clk   (ap_clk),
            .reset    (reset),
            .response (response),
            .pop      (pops[lane]),
            .head     (heads[lane]),
            .status   (statuses[lane]),
            .overflow (overflow[lane])
        );

        assign fifo_reset_busy[lane] = statuses[lane].reset_busy;
    end

    assign setup_busy = reset | (|fifo_reset_busy);

    config_drain_arbiter u_drain (
        .ap_clk     (ap_clk),
        .reset      (reset),
        .heads      (heads),
        .statuses   (statuses),
        .pops       (pops),
        .config_out (config_out)
    );

endmodule

`default_nettype wire

// ==== source/config_drain_arbiter.sv ====
// Round-robin configuration drain
`timescale 1ns/1ns
`default_nettype none

module config_drain_arbiter (
    input  logic                                  ap_clk,
    input  logic                                  reset,
    input  filter_cfg_pkg::filter_cond_param      heads [filter_cfg_pkg::NUM_LANES],
    input  filter_cfg_pkg::lane_fifo_status       statuses [filter_cfg_pkg::NUM_LANES],
    output logic [filter_cfg_pkg::NUM_LANES-1:0]  pops,
    output filter_cfg_pkg::tagged_config          config_out
);

    import filter_cfg_pkg::*;

    type_lane_id last_lane;
    type_lane_id grant_lane;
    logic        grant_found;

    // --------------------------------------------------------------------------
    // Lane choice
    // --------------------------------------------------------------------------
    // Search starts one past the lane served last
    always_comb begin
        type_lane_id cand;
        grant_found = 1'b0;
        grant_lane  = last_lane;
        for (int i = 1; i <= NUM_LANES; i++) begin
            cand = last_lane + type_lane_id'(i);
            if (!grant_found && !statuses[cand].empty) begin
                grant_found = 1'b1;
                grant_lane  = cand;
            end
        end
    end

    assign pops = grant_found ? (NUM_LANES'(1) << grant_lane) : '0;

    // --------------------------------------------------------------------------
    // Served lane tracking
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            // Lane 0 comes first
            last_lane <= type_lane_id'(NUM_LANES - 1);
        end else if (grant_found) begin
            last_lane <= grant_lane;
        end
    end

    // --------------------------------------------------------------------------
    // Output register
    // --------------------------------------------------------------------------
    // Head data lands one cycle after its pop
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            config_out.valid <= 1'b0;
        end else begin
            config_out.valid <= statuses[last_lane].valid;
        end
        config_out.lane  <= last_lane;
        config_out.param <= heads[last_lane];
    end

endmodule

`default_nettype wire

// ==== source/filter_cond_config_loader.sv ====
// Per-lane filter condition loader
`timescale 1ns/1ns
`default_nettype none

module filter_cond_config_loader #(
    parameter int LANE_INDEX = 0
) (
    input  logic                             ap_clk,
    input  logic                             reset,
    input  filter_cfg_pkg::cfg_response      response,
    input  logic                             pop,
    output filter_cfg_pkg::filter_cond_param head,
    output filter_cfg_pkg::lane_fifo_status  status,
    output logic                             overflow
);

    import filter_cfg_pkg::*;

    // Window of offsets owned by this lane
    localparam int WINDOW_MIN = LANE_INDEX * CFG_SEQ_WIDTH;
    localparam int WINDOW_MAX = WINDOW_MIN + CFG_SEQ_WIDTH;

    // Position of the word after the operation word
    localparam logic [CFG_SEQ_WIDTH-1:0] POS_SECOND = CFG_SEQ_WIDTH'(2);

    cfg_response              response_reg;
    logic                     word_in_window;
    logic                     word_is_first;
    type_loader_state         state;
    logic [CFG_SEQ_WIDTH-1:0] word_pos;
    filter_cond_param         record;
    logic                     fifo_wr_en;

    // --------------------------------------------------------------------------
    // Input register and window check
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            response_reg.valid <= 1'b0;
        end else begin
            response_reg.valid <= response.valid;
        end
        response_reg.offset <= response.offset;
        response_reg.data   <= response.data;
    end

    assign word_in_window = response_reg.valid
                         && (int'(response_reg.offset) >= WINDOW_MIN)
                         && (int'(response_reg.offset) < WINDOW_MAX);

    assign word_is_first = word_in_window && (int'(response_reg.offset) == WINDOW_MIN);

    // --------------------------------------------------------------------------
    // Collection FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            state    <= IDLE;
            word_pos <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (word_is_first) begin
                        state    <= COLLECT;
                        word_pos <= POS_SECOND;
                    end
                end
                COLLECT: begin
                    if (word_is_first) begin
                        // Partial record is abandoned
                        word_pos <= POS_SECOND;
                    end else if (word_in_window) begin
                        if (word_pos[CFG_SEQ_WIDTH-1]) begin
                            state    <= EMIT;
                            word_pos <= '0;
                        end else begin
                            word_pos <= word_pos << 1;
                        end
                    end
                end
                EMIT: begin
                    // Back-to-back region after a restart
                    if (word_is_first) begin
                        state    <= COLLECT;
                        word_pos <= POS_SECOND;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Field capture
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_is_first) begin
            record.operation <= type_filter_operation'(
                response_reg.data[$bits(type_filter_operation)-1:0]);
        end else if (word_in_window && state == COLLECT) begin
            case (word_pos)
                (CFG_SEQ_WIDTH'(1) << 1): record.filter_mask <= response_reg.data[MASK_BITS-1:0];
                (CFG_SEQ_WIDTH'(1) << 2): record.const_mask  <= response_reg.data[MASK_BITS-1:0];
                (CFG_SEQ_WIDTH'(1) << 3): record.const_value <= response_reg.data;
                (CFG_SEQ_WIDTH'(1) << 4): record.ops_mask    <= response_reg.data[OPS_MASK_BITS-1:0];
                (CFG_SEQ_WIDTH'(1) << 5): begin
                    record.break_flag       <= response_reg.data[0];
                    record.break_pass       <= response_reg.data[1];
                    record.filter_post      <= response_reg.data[2];
                    record.filter_pass      <= response_reg.data[3];
                    record.continue_flag    <= response_reg.data[4];
                    record.ternary_flag     <= response_reg.data[5];
                    record.conditional_flag <= response_reg.data[6];
                end
                (CFG_SEQ_WIDTH'(1) << 6): record.route_if   <= response_reg.data[$bits(type_route)-1:0];
                (CFG_SEQ_WIDTH'(1) << 7): record.route_else <= response_reg.data[$bits(type_route)-1:0];
                default: begin
                    record <= record;
                end
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Record queue
    // --------------------------------------------------------------------------
    assign fifo_wr_en = (state == EMIT) && !status.full;

    // Sticky until reset
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (state == EMIT && status.full) begin
            overflow <= 1'b1;
        end
    end

    config_fifo u_fifo (
        .ap_clk (ap_clk),
        .reset  (reset),
        .din    (record),
        .wr_en  (fifo_wr_en),
        .rd_en  (pop),
        .dout   (head),
        .status (status)
    );

endmodule

`default_nettype wire

// ==== source/config_fifo.sv ====
// Lane configuration FIFO
`timescale 1ns/1ns
`default_nettype none

module config_fifo (
    input  logic                             ap_clk,
    input  logic                             reset,
    input  filter_cfg_pkg::filter_cond_param din,
    input  logic                             wr_en,
    input  logic                             rd_en,
    output filter_cfg_pkg::filter_cond_param dout,
    output filter_cfg_pkg::lane_fifo_status  status
);

    import filter_cfg_pkg::*;

    localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
    localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);
    localparam logic [COUNT_BITS-1:0] COUNT_FULL = COUNT_BITS'(FIFO_DEPTH);

    filter_cond_param      mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  push;
    logic                  pull;
    logic                  read_valid;
    logic                  reset_busy_reg;

    // Full writes and empty reads are dropped
    assign push = wr_en && (count != COUNT_FULL);
    assign pull = rd_en && (count != '0);

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            read_valid <= 1'b0;
        end else begin
            read_valid <= pull;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pull) begin
            dout <= mem[rd_ptr];
        end
    end

    // Busy through reset and one cycle past it
    always_ff @(posedge ap_clk) begin
        reset_busy_reg <= reset;
    end

    assign status.full       = (count == COUNT_FULL);
    assign status.empty      = (count == '0);
    assign status.valid      = read_valid;
    assign status.reset_busy = reset_busy_reg;

endmodule

`default_nettype wire

// ==== source/cfg_response_sequencer.sv ====
// Configuration response sequencer
`timescale 1ns/1ns
`default_nettype none

module cfg_response_sequencer (
    input  logic                         ap_clk,
    input  logic                         reset,
    input  logic                         cfg_start,
    input  logic                         word_valid,
    input  filter_cfg_pkg::type_cfg_data word_data,
    output filter_cfg_pkg::cfg_response  response
);

    import filter_cfg_pkg::*;

    type_cfg_offset offset_count;
    type_cfg_offset word_offset;

    // A start pulse applies to the word of the same cycle
    assign word_offset = cfg_start ? '0 : offset_count;

    // --------------------------------------------------------------------------
    // Region offset counter
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            offset_count <= '0;
        end else if (word_valid) begin
            // Wraps at the end of the region
            offset_count <= word_offset + 1'b1;
        end else if (cfg_start) begin
            offset_count <= '0;
        end
    end

    // --------------------------------------------------------------------------
    // Tagged word register
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            response.valid <= 1'b0;
        end else begin
            response.valid <= word_valid;
        end
        if (word_valid) begin
            response.offset <= word_offset;
            response.data   <= word_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/filter_cfg_pkg.sv ====
// Filter configuration types
`default_nettype none

package filter_cfg_pkg;

    // --------------------------------------------------------------------------
    // Sizes
    // --------------------------------------------------------------------------
    localparam int NUM_LANES       = 4;
    localparam int LANE_ID_BITS    = 2;
    localparam int CFG_SEQ_WIDTH   = 8;
    localparam int CFG_OFFSET_BITS = 5;
    localparam int CFG_DATA_BITS   = 32;
    localparam int MASK_BITS       = 4;
    localparam int OPS_MASK_BITS   = 16;
    localparam int FIFO_DEPTH      = 4;

    // --------------------------------------------------------------------------
    // Vector types
    // --------------------------------------------------------------------------
    typedef logic [CFG_OFFSET_BITS-1:0] type_cfg_offset;
    typedef logic [CFG_DATA_BITS-1:0]   type_cfg_data;
    typedef logic [LANE_ID_BITS-1:0]    type_lane_id;
    typedef logic [MASK_BITS-1:0]       type_field_mask;
    typedef logic [OPS_MASK_BITS-1:0]   type_ops_mask;

    // Engine in the upper nibble, module in the lower
    typedef logic [7:0]                 type_route;

    // Comparison applied by the filter
    typedef enum logic [2:0] {
        EQ  = 3'd0,
        NE  = 3'd1,
        LT  = 3'd2,
        LE  = 3'd3,
        GT  = 3'd4,
        GE  = 3'd5,
        AND = 3'd6,
        OR  = 3'd7
    } type_filter_operation;

    // Loader FSM
    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        EMIT
    } type_loader_state;

    // --------------------------------------------------------------------------
    // Records
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic           valid;
        type_cfg_offset offset;
        type_cfg_data   data;
    } cfg_response;

    typedef struct packed {
        type_filter_operation operation;
        type_field_mask       filter_mask;
        type_field_mask       const_mask;
        type_cfg_data         const_value;
        type_ops_mask         ops_mask;
        logic                 break_flag;
        logic                 break_pass;
        logic                 filter_post;
        logic                 filter_pass;
        logic                 continue_flag;
        logic                 ternary_flag;
        logic                 conditional_flag;
        type_route            route_if;
        type_route            route_else;
    } filter_cond_param;

    typedef struct packed {
        logic full;
        logic empty;
        logic valid;
        logic reset_busy;
    } lane_fifo_status;

    typedef struct packed {
        logic             valid;
        type_lane_id      lane;
        filter_cond_param param;
    } tagged_config;

endpackage

`default_nettype wire
